// ==== Makefile ====
TOP = pipeCore_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module pipeCore -f files.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f
	out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// ==== design/cpuPkg.sv ====
/*
 * Shared widths, opcode encoding and pipeline payload types for the integer core.
 * Imported by every RTL stage and by the testbench reference model.
 */
package cpuPkg;

	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;
	localparam int NumRegs = 32;
	localparam int ConstWidth = 15;
	localparam int LuiShift = 17; // constant lands in bits 31..17

	// opcode field, instruction bits 31..26
	typedef enum logic [5:0] {
		OpNop  = 6'h00, // blank word, never executed
		// immediate group, destination is rt
		OpAddi = 6'h08, // sign-extended constant
		OpAndi = 6'h0c, // zero-extended constant
		OpOri  = 6'h0d,
		OpLui  = 6'h0f,
		// register group, destination is rd
		OpAdd  = 6'h20,
		OpSub  = 6'h21,
		OpAnd  = 6'h22,
		OpOr   = 6'h23,
		OpXor  = 6'h24,
		OpSlt  = 6'h25, // signed compare, 1 or 0
		// shift group, rt value shifted by the rs field
		OpSll  = 6'h28,
		OpSrl  = 6'h29,
		OpSra  = 6'h2a
	} opcodeE;

	// decoder output held in the decode register
	typedef struct packed {
		opcodeE                  op;
		logic [RegAddrWidth-1:0] rsIdx;   // also the shift amount
		logic [RegAddrWidth-1:0] rtIdx;
		logic [RegAddrWidth-1:0] destIdx; // rd or rt depending on op group
		logic [DataWidth-1:0]    imm;     // constant after extension
	} decodedOpT;

	// one register write travelling to the result output
	typedef struct packed {
		logic [RegAddrWidth-1:0] dest;
		logic [DataWidth-1:0]    value;
	} resultT;

endpackage

// ==== design/execStage.sv ====
/*
 * Execute stage. Picks operands from the in-flight results or the register file,
 * runs the ALU / shifter / immediate op and registers the result with its destination.
 */
`timescale 1ns/1ps

module execStage (
	input  logic                            clk,
	input  logic                            rstN,
	input  cpuPkg::decodedOpT               decOp,
	input  logic                            decValid,
	input  logic [cpuPkg::DataWidth-1:0]    rsData,
	input  logic [cpuPkg::DataWidth-1:0]    rtData,
	input  logic                            resultFree,
	input  cpuPkg::resultT                  commitResult,
	input  logic                            commitValid,
	output logic [cpuPkg::RegAddrWidth-1:0] rsAddr,
	output logic [cpuPkg::RegAddrWidth-1:0] rtAddr,
	output logic                            execAdvance,
	output cpuPkg::resultT                  execResult,
	output logic                            execValid
);
	import cpuPkg::*;

	logic rsHitExec;
	logic rtHitExec;
	logic rsHitCommit;
	logic rtHitCommit;
	logic [DataWidth-1:0] rsVal;
	logic [DataWidth-1:0] rtVal;
	logic [DataWidth-1:0] aluOut;
	logic [RegAddrWidth-1:0] shamt;

	// register file is addressed straight from the decoded op
	assign rsAddr = decOp.rsIdx;
	assign rtAddr = decOp.rtIdx;

	// youngest producer first: execute register, then result register
	assign rsHitExec = execValid && (execResult.dest == decOp.rsIdx);
	assign rtHitExec = execValid && (execResult.dest == decOp.rtIdx);
	assign rsHitCommit = commitValid && (commitResult.dest == decOp.rsIdx);
	assign rtHitCommit = commitValid && (commitResult.dest == decOp.rtIdx);

	assign rsVal = rsHitExec ? execResult.value :
		rsHitCommit ? commitResult.value : rsData;
	assign rtVal = rtHitExec ? execResult.value :
		rtHitCommit ? commitResult.value : rtData;

	assign shamt = decOp.rsIdx; // shift amount sits in the rs field

	always_comb begin
		case (decOp.op)
			OpAdd:  aluOut = rsVal + rtVal;
			OpSub:  aluOut = rsVal - rtVal;
			OpAnd:  aluOut = rsVal & rtVal;
			OpOr:   aluOut = rsVal | rtVal;
			OpXor:  aluOut = rsVal ^ rtVal;
			OpSlt:  aluOut = {{(DataWidth-1){1'b0}}, $signed(rsVal) < $signed(rtVal)};
			OpSll:  aluOut = rtVal << shamt;
			OpSrl:  aluOut = rtVal >> shamt;
			OpSra:  aluOut = $unsigned($signed(rtVal) >>> shamt); // keeps the sign bit
			OpAddi: aluOut = rsVal + decOp.imm;
			OpAndi: aluOut = rsVal & decOp.imm;
			OpOri:  aluOut = rsVal | decOp.imm;
			OpLui:  aluOut = decOp.imm << LuiShift;
			default: aluOut = '0; // NOPs never reach here
		endcase
	end

	// moves when empty or when the result register can take our content
	assign execAdvance = !execValid || resultFree;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			execValid <= 1'b0;
		end else if (execAdvance) begin
			execValid <= decValid;
		end
	end

	always_ff @(posedge clk) begin
		if (execAdvance && decValid) begin
			execResult.dest <= decOp.destIdx;
			execResult.value <= aluOut;
		end
	end

endmodule

// ==== design/instrDecoder.sv ====
/*
 * Input side of the core. Accepts instruction words under valid/ready, splits the
 * fields and keeps one decoded operation for the execute stage.
 */
`timescale 1ns/1ps

module instrDecoder (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic [cpuPkg::DataWidth-1:0] instr,
	input  logic                         instrValid,
	input  logic                         execAdvance,
	output logic                         instrReady,
	output cpuPkg::decodedOpT            decOp,
	output logic                         decValid
);
	import cpuPkg::*;

	logic [5:0] opField;
	logic [RegAddrWidth-1:0] rsField;
	logic [RegAddrWidth-1:0] rtField;
	logic [RegAddrWidth-1:0] rdField;
	logic [ConstWidth-1:0] constField;
	opcodeE op;
	logic isImmOp;
	logic [DataWidth-1:0] immExt;
	logic accept;

	// reference field layout with bit 25 unused
	assign opField = instr[31:26];
	assign rsField = instr[24:20]; // doubles as shift amount
	assign rtField = instr[19:15];
	assign rdField = instr[14:10];
	assign constField = instr[14:0];

	// anything outside the defined set collapses to a NOP
	always_comb begin
		case (opField)
			OpAdd, OpSub, OpAnd, OpOr, OpXor, OpSlt,
			OpSll, OpSrl, OpSra,
			OpAddi, OpAndi, OpOri, OpLui: op = opcodeE'(opField);
			default: op = OpNop;
		endcase
	end

	assign isImmOp = (op == OpAddi) || (op == OpAndi) || (op == OpOri) || (op == OpLui);

	always_comb begin
		if (op == OpAddi)
			immExt = {{(DataWidth-ConstWidth){constField[ConstWidth-1]}}, constField};
		else
			immExt = {{(DataWidth-ConstWidth){1'b0}}, constField}; // andi, ori, lui
	end

	// room when empty or when the held op moves on this cycle
	assign instrReady = !decValid || execAdvance;
	assign accept = instrValid && instrReady;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			decValid <= 1'b0;
		end else if (instrReady) begin
			decValid <= accept && (op != OpNop); // dropped words leave the slot empty
		end
	end

	// fields of the held op
	always_ff @(posedge clk) begin
		if (accept) begin
			decOp.op <= op;
			decOp.rsIdx <= rsField;
			decOp.rtIdx <= rtField;
			decOp.destIdx <= isImmOp ? rtField : rdField;
			decOp.imm <= immExt;
		end
	end

endmodule

// ==== design/pipeCore.sv ====
/*
 * Top level of the three-stage integer core: decode, execute, result.
 * Instruction words in on valid/ready, register writes out on valid/ready.
 */
`timescale 1ns/1ps

module pipeCore (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic [cpuPkg::DataWidth-1:0] instr,
	input  logic                         instrValid,
	output logic                         instrReady,
	output cpuPkg::resultT               result,
	output logic                         resultValid,
	input  logic                         resultReady
);
	import cpuPkg::*;

	decodedOpT decOp;
	logic decValid;
	logic execAdvance;

	resultT execResult;
	logic execValid;
	logic resultFree;

	logic [RegAddrWidth-1:0] rsAddr;
	logic [RegAddrWidth-1:0] rtAddr;
	logic [DataWidth-1:0] rsData;
	logic [DataWidth-1:0] rtData;

	logic writeEn;
	logic [RegAddrWidth-1:0] writeAddr;
	logic [DataWidth-1:0] writeData;

	instrDecoder i_instrDecoder (
		.clk, .rstN,
		.instr, .instrValid, .execAdvance,
		.instrReady, .decOp, .decValid
	);

	regFile i_regFile (
		.clk, .rstN,
		.writeEn, .writeAddr, .writeData,
		.rsAddr, .rtAddr,
		.rsData, .rtData
	);

	// result register content doubles as the second forwarding source
	execStage i_execStage (
		.clk, .rstN,
		.decOp, .decValid,
		.rsData, .rtData,
		.resultFree,
		.commitResult (result),
		.commitValid  (resultValid),
		.rsAddr, .rtAddr,
		.execAdvance, .execResult, .execValid
	);

	resultPort i_resultPort (
		.clk, .rstN,
		.execResult, .execValid,
		.resultReady,
		.resultFree, .result, .resultValid,
		.writeEn, .writeAddr, .writeData
	);

endmodule

// ==== design/regFile.sv ====
/*
 * 32 x 32 register file, two combinational read ports and one synchronous write.
 * Written only when a result leaves the core.
 */
`timescale 1ns/1ps

module regFile (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic                            writeEn,
	input  logic [cpuPkg::RegAddrWidth-1:0] writeAddr,
	input  logic [cpuPkg::DataWidth-1:0]    writeData,
	input  logic [cpuPkg::RegAddrWidth-1:0] rsAddr,
	input  logic [cpuPkg::RegAddrWidth-1:0] rtAddr,
	output logic [cpuPkg::DataWidth-1:0]    rsData,
	output logic [cpuPkg::DataWidth-1:0]    rtData
);
	import cpuPkg::*;

	logic [DataWidth-1:0] regs [NumRegs];

	// every register reads zero after reset
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	// same-cycle write is seen through result forwarding, not here
	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];

endmodule

// ==== design/resultPort.sv ====
/*
 * Output side of the core. Holds one result, presents it under valid/ready
 * and commits it to the register file on the accepting edge.
 */
`timescale 1ns/1ps

module resultPort (
	input  logic                            clk,
	input  logic                            rstN,
	input  cpuPkg::resultT                  execResult,
	input  logic                            execValid,
	input  logic                            resultReady,
	output logic                            resultFree,
	output cpuPkg::resultT                  result,
	output logic                            resultValid,
	output logic                            writeEn,
	output logic [cpuPkg::RegAddrWidth-1:0] writeAddr,
	output logic [cpuPkg::DataWidth-1:0]    writeData
);
	import cpuPkg::*;

	logic handshake;

	assign handshake = resultValid && resultReady;
	assign resultFree = !resultValid || resultReady; // empty or leaving now

	always_ff @(posedge clk) begin
		if (!rstN) begin
			resultValid <= 1'b0;
		end else if (resultFree) begin
			resultValid <= execValid;
		end
	end

	// held steady while the consumer stalls
	always_ff @(posedge clk) begin
		if (resultFree && execValid) begin
			result <= execResult;
		end
	end

	// register write lands on the same edge as the handshake
	assign writeEn = handshake;
	assign writeAddr = result.dest;
	assign writeData = result.value;

endmodule

// ==== files.f ====
design/cpuPkg.sv
design/instrDecoder.sv
design/regFile.sv
design/execStage.sv
design/resultPort.sv
design/pipeCore.sv
test/pipeCore_sva.sv
test/pipeCore_tb.sv

// ==== test/pipeCore_sva.sv ====
/*
 * Reset and valid/ready stability checks for the core's ports, bound into pipeCore.
 */
`timescale 1ns/1ps

module pipeCore_sva (
	input logic                         clk,
	input logic                         rstN,
	input logic [cpuPkg::DataWidth-1:0] instr,
	input logic                         instrValid,
	input logic                         instrReady,
	input cpuPkg::resultT               result,
	input logic                         resultValid,
	input logic                         resultReady
);

	int failCount = 0;

	// output register comes out of reset empty
	resetEmpty: assert property (@(posedge clk) !rstN |=> !resultValid)
	else begin
		$error("resultValid high right after a reset cycle");
		failCount++;
	end

	// decoder slot empty after reset, so input side is open
	resetReady: assert property (@(posedge clk) !rstN |=> instrReady)
	else begin
		$error("instrReady low right after a reset cycle");
		failCount++;
	end

	resultHeld: assert property (@(posedge clk) disable iff (!rstN)
		resultValid && !resultReady |=> resultValid && $stable(result))
	else begin
		$error("result dropped or changed while the consumer stalled");
		failCount++;
	end

	// producer side rule on the instruction input
	instrHeld: assert property (@(posedge clk) disable iff (!rstN)
		instrValid && !instrReady |=> instrValid && $stable(instr))
	else begin
		$error("instruction word dropped or changed while waiting");
		failCount++;
	end

endmodule

bind pipeCore pipeCore_sva i_pipeCore_sva (
	.clk(clk),
	.rstN(rstN),
	.instr(instr),
	.instrValid(instrValid),
	.instrReady(instrReady),
	.result(result),
	.resultValid(resultValid),
	.resultReady(resultReady)
);

// ==== test/pipeCore_tb.sv ====
/*
 * Testbench for the integer core. Streams instruction words, replays them on a
 * register model and checks every accepted result against the model's queue.
 */
`timescale 1ns/1ps

module pipeCore_tb;
	import cpuPkg::*;

	localparam int ClkPeriod = 4;
	localparam int ResetCycles = 10;
	localparam int ChainLen = 48;
	localparam int ImmCount = 40;
	localparam int MixCount = 150;
	localparam int DropCount = 100;
	// reset probe, chain plus 6 seeds, 5 words per shift amount
	localparam int TotalInstr = 1 + (6 + ChainLen) + ImmCount + 32 * 5 + MixCount + DropCount;
	localparam int WatchdogCycles = TotalInstr * 20 + ResetCycles;

	logic clk = 1'b0;
	logic rstN;
	logic [DataWidth-1:0] instr;
	logic instrValid;
	logic instrReady;
	resultT result;
	logic resultValid;
	logic resultReady;

	logic randomReady;
	logic [DataWidth-1:0] modelRegs [NumRegs];
	resultT expQ [$]; // oldest expected result at the front
	int errorCount = 0;
	int resultCount = 0;
	int writesSent = 0;
	int testErrStart = 0;
	int testResStart = 0;
	int testWriteStart = 0;

	pipeCore i_pipeCore (
		.clk, .rstN,
		.instr, .instrValid, .instrReady,
		.result, .resultValid, .resultReady
	);

	always #(ClkPeriod / 2) clk = ~clk;

	// consumer stalls at random while back-pressure is on
	always @(negedge clk) begin
		if (randomReady)
			resultReady = 1'($urandom());
		else
			resultReady = 1'b1;
	end

	function automatic logic [31:0] encodeReg(input logic [5:0] op, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {op, 1'b0, rs, rt, rd, 10'd0};
	endfunction

	function automatic logic [31:0] encodeImm(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [14:0] k);
		return {op, 1'b0, rs, rt, k};
	endfunction

	// runs one word on the model and returns 0 for words that write nothing
	function automatic bit modelExec(input logic [31:0] w, output resultT r);
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] dest;
		logic [14:0] k;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] v;
		rs = w[24:20];
		rt = w[19:15];
		dest = w[14:10];
		k = w[14:0];
		a = modelRegs[rs];
		b = modelRegs[rt];
		case (w[31:26])
			OpAdd: v = a + b;
			OpSub: v = a - b;
			OpAnd: v = a & b;
			OpOr:  v = a | b;
			OpXor: v = a ^ b;
			OpSlt: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OpSll: v = b << rs; // rs field is the amount
			OpSrl: v = b >> rs;
			OpSra: v = (b >> rs) | (b[31] ? ~(32'hffff_ffff >> rs) : 32'd0);
			OpAddi: {dest, v} = {rt, a + {{17{k[14]}}, k}};
			OpAndi: {dest, v} = {rt, a & {17'd0, k}};
			OpOri:  {dest, v} = {rt, a | {17'd0, k}};
			OpLui:  {dest, v} = {rt, k, 17'd0};
			default: return 1'b0; // blank or undefined word
		endcase
		modelRegs[dest] = v;
		r.dest = dest;
		r.value = v;
		return 1'b1;
	endfunction

	function automatic logic [5:0] chainOp(input int n);
		case (n % 6)
			0: return OpAdd;
			1: return OpSub;
			2: return OpAnd;
			3: return OpOr;
			4: return OpXor;
			default: return OpSlt;
		endcase
	endfunction

	// one of the thirteen writing opcodes with random fields and spare bit
	function automatic logic [31:0] randomWord();
		logic [5:0] op;
		case ($urandom_range(12, 0))
			0: op = OpAdd;
			1: op = OpSub;
			2: op = OpAnd;
			3: op = OpOr;
			4: op = OpXor;
			5: op = OpSlt;
			6: op = OpSll;
			7: op = OpSrl;
			8: op = OpSra;
			9: op = OpAddi;
			10: op = OpAndi;
			11: op = OpOri;
			default: op = OpLui;
		endcase
		return {op, 26'($urandom())};
	endfunction

	function automatic logic [31:0] undefinedWord();
		logic [5:0] op;
		case ($urandom_range(3, 0))
			0: op = 6'h01;
			1: op = 6'h10;
			2: op = 6'h2b;
			default: op = 6'h3f;
		endcase
		return {op, 26'($urandom())};
	endfunction

	// called on a falling edge and returns on the falling edge after the transfer
	task automatic sendWord(input logic [31:0] w);
		resultT r;
		logic accepted;
		if (modelExec(w, r)) begin
			expQ.push_back(r);
			writesSent++;
		end
		instr = w;
		instrValid = 1'b1;
		do begin
			#1;
			accepted = instrReady;
			@(negedge clk);
		end while (!accepted);
	endtask

	task automatic drain();
		instrValid = 1'b0;
		while (expQ.size() != 0)
			@(negedge clk);
	endtask

	task automatic report(input string name);
		$display("test %s done: %0d results, %0d errors", name,
			resultCount - testResStart, errorCount - testErrStart);
		testErrStart = errorCount;
		testResStart = resultCount;
		testWriteStart = writesSent;
	endtask

	always @(posedge clk) begin : checkResult
		resultT expected;
		if (rstN && resultValid && resultReady) begin
			resultCount++;
			if (expQ.size() == 0) begin
				$display("result for r%0d arrived with nothing outstanding", result.dest);
				errorCount++;
			end else begin
				expected = expQ.pop_front();
				assert (result.dest == expected.dest) else begin
					$display("mismatch result.dest: got 0x%h expected 0x%h",
						result.dest, expected.dest);
					errorCount++;
				end
				assert (result.value == expected.value) else begin
					$display("mismatch result.value: got 0x%h expected 0x%h",
						result.value, expected.value);
					errorCount++;
				end
			end
		end
	end

	initial begin : watchdog
		#(WatchdogCycles * ClkPeriod);
		$display("watchdog expired with %0d results still outstanding", expQ.size());
		$display("Simulation FAILED");
		$finish;
	end

	initial begin : stimulus
		logic [4:0] prev1;
		logic [4:0] prev2;
		logic [4:0] rd;
		int sel;
		int svaFails;
		rstN = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		resultReady = 1'b1;
		randomReady = 1'b0;
		for (int i = 0; i < NumRegs; i++)
			modelRegs[5'(i)] = '0;
		void'($urandom(32'ha7d5));
		repeat (ResetCycles) @(negedge clk);
		rstN = 1'b1;

		@(negedge clk);
		#1;
		assert (!resultValid && instrReady) else begin
			$display("after reset resultValid is high or instrReady is low");
			errorCount++;
		end
		@(negedge clk);
		sendWord(encodeReg(OpAdd, 5'd3, 5'd1, 5'd2)); // both sources untouched
		drain();
		report("reset and first add");

		for (int i = 1; i <= 6; i++)
			sendWord(encodeImm(OpAddi, 5'(i), 5'd0, 15'($urandom())));
		prev2 = 5'd5;
		prev1 = 5'd6;
		for (int i = 0; i < ChainLen; i++) begin
			rd = 5'(7 + i % 20);
			sendWord(encodeReg(chainOp(i), rd, prev1, prev2)); // rs from exec and rt from result reg
			prev2 = prev1;
			prev1 = rd;
		end
		drain();
		report("dependent register ops");

		for (int i = 0; i < ImmCount; i++) begin
			rd = 5'($urandom());
			case (i % 4)
				0: sendWord(encodeImm(OpAddi, rd, 5'($urandom()), {1'b1, 14'($urandom())}));
				1: sendWord(encodeImm(OpAndi, rd, 5'($urandom()), 15'($urandom())));
				2: sendWord(encodeImm(OpOri, rd, 5'($urandom()), 15'($urandom())));
				default: sendWord(encodeImm(OpLui, rd, 5'd0, 15'($urandom())));
			endcase
		end
		drain();
		report("immediates and load-upper");

		for (int sh = 0; sh < 32; sh++) begin
			sendWord(encodeImm(OpLui, 5'd20, 5'd0, {1'b1, 14'($urandom())})); // sign bit set
			sendWord(encodeImm(OpOri, 5'd20, 5'd20, 15'($urandom())));
			sendWord(encodeReg(OpSll, 5'd21, 5'(sh), 5'd20));
			sendWord(encodeReg(OpSrl, 5'd22, 5'(sh), 5'd20));
			sendWord(encodeReg(OpSra, 5'd23, 5'(sh), 5'd20));
		end
		drain();
		report("shifts");

		randomReady = 1'b1;
		for (int i = 0; i < MixCount; i++)
			sendWord(randomWord());
		drain();
		report("random back-pressure");

		for (int i = 0; i < DropCount; i++) begin
			sel = $urandom_range(3, 0);
			if (sel == 0)
				sendWord('0);
			else if (sel == 1)
				sendWord(undefinedWord());
			else
				sendWord(randomWord());
		end
		drain();
		randomReady = 1'b0;
		repeat (4) @(negedge clk); // quiet window so a stray result gets counted
		assert (resultCount - testResStart == writesSent - testWriteStart && expQ.size() == 0)
		else begin
			$display("got %0d results for %0d writing words, %0d still expected",
				resultCount - testResStart, writesSent - testWriteStart, expQ.size());
			errorCount++;
		end
		report("dropped words");

		svaFails = i_pipeCore.i_pipeCore_sva.failCount;
		$display("results: %0d, errors: %0d, bound assertion failures: %0d",
			resultCount, errorCount, svaFails);
		if (errorCount == 0 && svaFails == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
